// File: Bender.yml
package:
  name: stair_game

sources:
  - include_dirs:
      - source
    files:
      - source/stair_pkg.sv
      - source/game_fsm.sv
      - source/player_motion.sv
      - source/stair_field.sv
      - source/score_display.sv
      - source/matrix_scan.sv
      - source/stair_game.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/stair_checker.sv
      - testbench/tb_stair_game.sv

// File: source/game_fsm.sv
`timescale 1ns/10ps
`include "stair_params.svh"

module game_fsm import stair_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       landed,
	input  logic       fell,
	input  logic       land_done,
	output game_ctrl_t ctrl
);

	localparam int TICK_W = $clog2(`GAME_MOVE_TICKS + 1);

	typedef enum logic [2:0] {
		S_RESET,
		S_IDLE,
		S_LOAD,
		S_MOVE,
		S_LAND
	} state_t;

	state_t            state;
	state_t            state_nx;
	logic [TICK_W-1:0] tick_cnt;
	logic              tick_last;

	assign tick_last = (tick_cnt == TICK_W'(`GAME_MOVE_TICKS - 1));

	////////////////////////////////////////////////////////////
	// state machine
	always_comb begin
		state_nx = state;
		case (state)
			S_RESET: state_nx = S_IDLE;
			S_IDLE: begin
				if (start) begin
					state_nx = S_LOAD;
				end
			end
			S_LOAD: state_nx = S_MOVE;
			S_MOVE: begin
				if (fell) begin
					state_nx = S_RESET; // game over
				end else if (landed) begin
					state_nx = S_LAND;
				end
			end
			S_LAND: begin
				if (land_done) begin
					state_nx = S_MOVE;
				end
			end
			default: state_nx = S_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_RESET;
		end else begin
			state <= state_nx;
		end
	end

	// move step divider, starts over each time move is entered
	always_ff @(posedge clk) begin
		if (rst || state != S_MOVE || tick_last) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	always_comb begin
		ctrl.clear     = (state == S_RESET);
		ctrl.load      = (state == S_LOAD);
		ctrl.step      = (state == S_MOVE) && tick_last;
		ctrl.land_busy = (state == S_LAND);
		ctrl.playing   = (state == S_LOAD) || (state == S_MOVE) || (state == S_LAND);
	end

endmodule

// File: source/matrix_scan.sv
`timescale 1ns/10ps
`include "stair_params.svh"

module matrix_scan import stair_pkg::*; (
	input  logic       clk,
	input  game_ctrl_t ctrl,
	input  field_t     field,
	input  pos_t       pos,
	output logic [7:0] row,
	output logic [7:0] col
);

	localparam int BLINK_W = $clog2(`SCAN_BLINK_TICKS + 1);

	logic [2:0]         scan_y;   // height being driven
	logic [BLINK_W-1:0] blink_cnt;
	logic               blink_on;
	logic [7:0]         row_bits;

	// column 0 lands on bit 7
	always_comb begin
		for (int x = 0; x < `STAIR_WIDTH; x++) begin
			row_bits[`STAIR_WIDTH - 1 - x] = (field[x][scan_y] == CELL_SOLID)
				|| (field[x][scan_y] == CELL_FADING && blink_on)
				|| (pos.x == 3'(x) && pos.y == scan_y);
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.clear) begin
			scan_y    <= '0;
			blink_cnt <= '0;
			blink_on  <= 1'b0;
		end else begin
			scan_y <= scan_y + 3'd1;
			if (blink_cnt == BLINK_W'(`SCAN_BLINK_TICKS - 1)) begin
				blink_cnt <= '0;
				blink_on  <= ~blink_on;
			end else begin
				blink_cnt <= blink_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		row <= ctrl.playing ? row_bits : 8'd0; // dark outside a game
		col <= 8'b1000_0000 >> scan_y;
	end

endmodule

// File: source/player_motion.sv
`timescale 1ns/10ps
`include "stair_params.svh"

module player_motion import stair_pkg::*; (
	input  logic       clk,
	input  game_ctrl_t ctrl,
	input  logic       left,
	input  logic       right,
	input  field_t     field,
	output pos_t       pos,
	output logic       landed,
	output logic       fell
);

	localparam int JUMP_STEPS = 2; // rises per jump

	logic [1:0] jump_cnt;
	logic       rising;
	logic [2:0] nx_x;    // column after this step's move
	logic [2:0] below_y;
	logic       on_stair;

	// left goes to higher columns, right to lower ones
	always_comb begin
		nx_x = pos.x;
		if (right && pos.x != 3'd0) begin
			nx_x = pos.x - 3'd1;
		end else if (left && pos.x != 3'(`STAIR_WIDTH - 1)) begin
			nx_x = pos.x + 3'd1;
		end
	end

	assign below_y  = pos.y - 3'd1;
	assign on_stair = (field[nx_x][below_y] != CELL_EMPTY); // checked at the new column

	always_ff @(posedge clk) begin
		landed <= 1'b0;
		fell   <= 1'b0;
		if (ctrl.clear || ctrl.load) begin
			pos.x    <= 3'(`PLAYER_START_X);
			pos.y    <= 3'(`PLAYER_START_Y);
			jump_cnt <= '0;
			rising   <= 1'b1;
		end else if (ctrl.step) begin
			pos.x <= nx_x;
			if (rising) begin
				if (pos.y != 3'(`STAIR_WIDTH - 1)) begin
					pos.y <= pos.y + 3'd1;
				end
				jump_cnt <= jump_cnt + 2'd1;
				rising   <= (jump_cnt != 2'(JUMP_STEPS - 1)); // last rise of this jump
			end else if (!on_stair) begin
				pos.y <= below_y;
				fell  <= (below_y == 3'd0);
			end else if (pos.y == 3'(`LAND_HEIGHT)) begin
				// the field scrolls down by two under the player
				pos.y    <= 3'(`LAND_HEIGHT - 2);
				landed   <= 1'b1;
				jump_cnt <= '0;
				rising   <= 1'b1;
			end else begin
				pos.y    <= pos.y + 3'd1; // stood on a stair, jump again at once
				jump_cnt <= 2'd1;
				rising   <= 1'b1;
			end
		end
	end

endmodule

// File: source/score_display.sv
`timescale 1ns/10ps

module score_display import stair_pkg::*; (
	input  logic        clk,
	input  game_ctrl_t  ctrl,
	input  logic        stair_added,
	output score_t      score,
	output seg_digits_t seg
);

	logic [11:0] bcd; // hundreds, tens, ones

	function automatic logic [7:0] seg_code(input logic [3:0] digit);
		case (digit)
			4'd0:    seg_code = 8'b1100_0000;
			4'd1:    seg_code = 8'b1111_1001;
			4'd2:    seg_code = 8'b1010_0100;
			4'd3:    seg_code = 8'b1011_0000;
			4'd4:    seg_code = 8'b1001_1001;
			4'd5:    seg_code = 8'b1001_0010;
			4'd6:    seg_code = 8'b1000_0010;
			4'd7:    seg_code = 8'b1111_1000;
			4'd8:    seg_code = 8'b1000_0000;
			4'd9:    seg_code = 8'b1001_0000;
			default: seg_code = 8'b1111_1111; // blank
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (ctrl.clear || ctrl.load) begin
			score <= '0;
		end else if (stair_added) begin
			score <= score + 10'd1;
		end
	end

	// shift and add 3
	// hundreds stays below 5 before its last shift up to 999, so no fixup there
	always_comb begin
		bcd = '0;
		for (int i = 9; i >= 0; i--) begin
			if (bcd[3:0] >= 4'd5) begin
				bcd[3:0] = bcd[3:0] + 4'd3;
			end
			if (bcd[7:4] >= 4'd5) begin
				bcd[7:4] = bcd[7:4] + 4'd3;
			end
			bcd = {bcd[10:0], score[i]};
		end
	end

	always_ff @(posedge clk) begin
		seg.hundreds <= seg_code(bcd[11:8]); // 1000 and up shows blank
		seg.tens     <= seg_code(bcd[7:4]);
		seg.ones     <= seg_code(bcd[3:0]);
	end

endmodule

// File: source/stair_field.sv
`timescale 1ns/10ps
`include "stair_params.svh"

module stair_field import stair_pkg::*; (
	input  logic       clk,
	input  game_ctrl_t ctrl,
	input  pos_t       pos,
	input  score_t     score,
	output field_t     field,
	output logic       stair_added,
	output logic       land_done
);

	logic [1:0] land_seq;    // 0 fade, 1..2 scroll, 3 generate
	logic [2:0] rand_pos;
	logic [4:0] rand_kind;
	logic [4:0] solid_limit;
	logic       new_solid;
	cell_t      new_cell;
	logic [2:0] new_left;    // lowest column of the new stair

	////////////////////////////////////////////////////////////
	// difficulty and new stair choice
	always_comb begin
		if (score < `DIFF_SCORE_1) begin
			solid_limit = 5'(`DIFF_PROB_0);
		end else if (score < `DIFF_SCORE_2) begin
			solid_limit = 5'(`DIFF_PROB_1);
		end else if (score < `DIFF_SCORE_3) begin
			solid_limit = 5'(`DIFF_PROB_2);
		end else if (score < `DIFF_SCORE_4) begin
			solid_limit = 5'(`DIFF_PROB_3);
		end else if (score < `DIFF_SCORE_5) begin
			solid_limit = 5'(`DIFF_PROB_4);
		end else if (score == `DIFF_SCORE_5) begin
			solid_limit = 5'(`DIFF_PROB_5);
		end else begin
			solid_limit = 5'(`DIFF_PROB_6);
		end
	end

	assign new_solid = (rand_kind <= solid_limit);
	assign new_cell  = new_solid ? CELL_SOLID : CELL_FADING;

	// last two placements depend on the stair kind
	always_comb begin
		case (rand_pos)
			3'd6:    new_left = new_solid ? 3'd0 : 3'd1;
			3'd7:    new_left = new_solid ? 3'd2 : 3'd3;
			default: new_left = rand_pos;
		endcase
	end

	assign land_done   = ctrl.land_busy && (land_seq == 2'd3);
	assign stair_added = land_done;

	always_ff @(posedge clk) begin
		if (ctrl.clear || !ctrl.land_busy) begin
			land_seq <= '0;
		end else begin
			land_seq <= land_seq + 2'd1;
		end
	end

	// free running, sampled whenever a stair is generated
	always_ff @(posedge clk) begin
		if (ctrl.clear) begin
			rand_pos  <= 3'd1;
			rand_kind <= 5'd1;
		end else begin
			rand_pos  <= rand_pos + 3'd1;
			rand_kind <= rand_kind + 5'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// playfield
	always_ff @(posedge clk) begin
		if (ctrl.clear || ctrl.load) begin
			for (int x = 0; x < `STAIR_WIDTH; x++) begin
				for (int y = 0; y < `STAIR_WIDTH; y++) begin
					field[x][y] <= CELL_EMPTY;
				end
			end
			if (ctrl.load) begin
				for (int i = 0; i < `STAIR_LEN; i++) begin // starting layout
					field[1 + i][1] <= CELL_SOLID;
					field[5 + i][3] <= CELL_SOLID;
					field[2 + i][5] <= CELL_SOLID;
					field[5 + i][7] <= CELL_SOLID;
				end
			end
		end else if (ctrl.land_busy) begin
			case (land_seq)
				2'd0: begin
					if (field[pos.x][`LAND_HEIGHT - 1] == CELL_FADING) begin
						for (int x = 0; x < `STAIR_WIDTH; x++) begin
							field[x][`LAND_HEIGHT - 1] <= CELL_EMPTY;
						end
					end
				end
				2'd1, 2'd2: begin
					for (int x = 0; x < `STAIR_WIDTH; x++) begin
						for (int y = 0; y < `STAIR_WIDTH - 1; y++) begin
							field[x][y] <= field[x][y + 1];
						end
						field[x][`STAIR_WIDTH - 1] <= CELL_EMPTY;
					end
				end
				default: begin
					for (int i = 0; i < `STAIR_LEN; i++) begin
						field[new_left + i][`STAIR_WIDTH - 1] <= new_cell;
					end
				end
			endcase
		end
	end

endmodule

// File: source/stair_game.sv
`timescale 1ns/10ps

module stair_game import stair_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       left,
	input  logic       right,
	output logic [7:0] row,
	output logic [7:0] col,
	output logic [7:0] seg7_3,
	output logic [7:0] seg7_2,
	output logic [7:0] seg7_1,
	output logic       playing
);

	game_ctrl_t  ctrl;
	pos_t        pos;
	field_t      field;
	score_t      score;
	seg_digits_t seg;
	logic        landed;
	logic        fell;
	logic        stair_added;
	logic        land_done;

	game_fsm i_game_fsm (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.landed    (landed),
		.fell      (fell),
		.land_done (land_done),
		.ctrl      (ctrl)
	);

	player_motion i_player_motion (
		.clk    (clk),
		.ctrl   (ctrl),
		.left   (left),
		.right  (right),
		.field  (field),
		.pos    (pos),
		.landed (landed),
		.fell   (fell)
	);

	stair_field i_stair_field (
		.clk         (clk),
		.ctrl        (ctrl),
		.pos         (pos),
		.score       (score),
		.field       (field),
		.stair_added (stair_added),
		.land_done   (land_done)
	);

	score_display i_score_display (
		.clk         (clk),
		.ctrl        (ctrl),
		.stair_added (stair_added),
		.score       (score),
		.seg         (seg)
	);

	matrix_scan i_matrix_scan (
		.clk   (clk),
		.ctrl  (ctrl),
		.field (field),
		.pos   (pos),
		.row   (row),
		.col   (col)
	);

	assign seg7_3  = seg.hundreds;
	assign seg7_2  = seg.tens;
	assign seg7_1  = seg.ones;
	assign playing = ctrl.playing;

endmodule

// File: source/stair_params.svh
`ifndef STAIR_PARAMS_SVH
`define STAIR_PARAMS_SVH

// matrix geometry
`define STAIR_WIDTH 8
`define STAIR_LEN   3

// clock cycles per move step
`define GAME_MOVE_TICKS 150
`define SCAN_BLINK_TICKS 150 // blink half period

`define PLAYER_START_X 2
`define PLAYER_START_Y 2
`define LAND_HEIGHT    4     // standing here scores a stair

// score thresholds where the game gets harder
`define DIFF_SCORE_1 20
`define DIFF_SCORE_2 30
`define DIFF_SCORE_3 40
`define DIFF_SCORE_4 50
`define DIFF_SCORE_5 60

// new stair is solid while the 5-bit counter is at or below these
`define DIFF_PROB_0 31
`define DIFF_PROB_1 28
`define DIFF_PROB_2 25
`define DIFF_PROB_3 20
`define DIFF_PROB_4 15
`define DIFF_PROB_5 10
`define DIFF_PROB_6 0

`endif

// File: source/stair_pkg.sv
`include "stair_params.svh"

package stair_pkg;

	typedef enum logic [1:0] {
		CELL_EMPTY  = 2'd0,
		CELL_SOLID  = 2'd1,
		CELL_FADING = 2'd2 // vanishes once stood on
	} cell_t;

	// indexed [column][height], height 0 at the bottom
	typedef cell_t [`STAIR_WIDTH-1:0][`STAIR_WIDTH-1:0] field_t;

	typedef struct packed {
		logic [2:0] x;
		logic [2:0] y;
	} pos_t;

	typedef struct packed {
		logic clear;     // empty everything
		logic load;      // new game
		logic step;      // one move step
		logic land_busy; // landing sequence running
		logic playing;
	} game_ctrl_t;

	// active low segments, one byte per digit
	typedef struct packed {
		logic [7:0] hundreds;
		logic [7:0] tens;
		logic [7:0] ones;
	} seg_digits_t;

	typedef logic [9:0] score_t;

endpackage

// File: testbench/stair_checker.sv
`timescale 1ns/10ps

module stair_checker (
	input  logic       clk,
	input  logic [7:0] row,
	input  logic [7:0] col,
	input  logic [7:0] seg_h,
	input  logic [7:0] seg_t,
	input  logic [7:0] seg_o,
	input  logic       playing,
	input  logic       check_req,
	input  logic       check_last,
	input  logic [2:0] check_kind,
	input  int         exp_score,
	input  logic       exp_playing,
	input  int         exp_y,
	input  int         test_id,
	output int         pass_cnt,
	output int         fail_cnt
);

	localparam logic [2:0] K_IDLE   = 3'd0;
	localparam logic [2:0] K_LAYOUT = 3'd1;
	localparam logic [2:0] K_BOUNCE = 3'd2;
	localparam logic [2:0] K_LANDED = 3'd3;
	localparam logic [2:0] K_SCORE  = 3'd4;
	localparam logic [2:0] K_OVER   = 3'd5;

	logic [7:0] frame [8]; // indexed by height
	int         test_errs;

	initial begin
		pass_cnt  = 0;
		fail_cnt  = 0;
		test_errs = 0;
	end

	// three cells from column lo with column 0 on bit 7
	function automatic logic [7:0] stair_mask(input int lo);
		return 8'b1110_0000 >> lo;
	endfunction

	function automatic logic [7:0] digit_pattern(input int d);
		case (d)
			0:       return 8'b1100_0000;
			1:       return 8'b1111_1001;
			default: return 8'b1111_1111;
		endcase
	endfunction

	task automatic report(input string msg);
		$display("error %0t: %s", $time, msg);
		test_errs++;
	endtask

	task automatic compare_row(input int h, input logic [7:0] exp);
		if (frame[h] !== exp) begin
			report($sformatf("height %0d lit %b, expected %b", h, frame[h], exp));
		end
	endtask

	// outputs settle after the rising edge
	always @(negedge clk) begin
		for (int b = 0; b < 8; b++) begin
			if (col[b]) begin
				frame[7 - b] <= row;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks requested by the testbench
	task automatic run_check();
		logic top_ok;
		top_ok = 1'b0;
		if (playing !== exp_playing) begin
			report($sformatf("playing is %b, expected %b", playing, exp_playing));
		end
		if (seg_h !== digit_pattern(exp_score / 100)
			|| seg_t !== digit_pattern(exp_score / 10 % 10)
			|| seg_o !== digit_pattern(exp_score % 10)) begin
			report($sformatf("digits %h %h %h do not show %03d", seg_h, seg_t, seg_o, exp_score));
		end
		case (check_kind)
			K_IDLE, K_OVER: begin
				for (int h = 0; h < 8; h++) begin
					compare_row(h, 8'd0); // dark matrix
				end
			end
			K_LAYOUT: begin
				compare_row(0, 8'd0);
				compare_row(1, stair_mask(1));
				compare_row(2, 8'h80 >> 2); // player
				compare_row(3, stair_mask(5));
				compare_row(4, 8'd0);
				compare_row(5, stair_mask(2));
				compare_row(6, 8'd0);
				compare_row(7, stair_mask(5));
			end
			K_BOUNCE: begin
				for (int h = 2; h <= 4; h++) begin
					if (frame[h][5] !== (h == exp_y)) begin
						report($sformatf("player pixel wrong at height %0d, expected height %0d",
							h, exp_y));
					end
				end
			end
			K_LANDED: begin
				compare_row(0, 8'd0);
				compare_row(1, stair_mask(5));
				compare_row(2, 8'h80 >> 5);
				compare_row(3, stair_mask(2)); // former height 5 stair
				compare_row(4, 8'd0);
				compare_row(5, stair_mask(5));
				compare_row(6, 8'd0);
				for (int k = 0; k < 6; k++) begin
					if (frame[7] === (8'b111 << k)) begin
						top_ok = 1'b1;
					end
				end
				if (!top_ok) begin
					report($sformatf("top row %b is not one three cell stair", frame[7]));
				end
			end
			K_SCORE: ; // score and playing only
			default: report($sformatf("unknown check kind %0d", check_kind));
		endcase
		if (check_last) begin
			if (test_errs == 0) begin
				$display("test %0d passed", test_id);
				pass_cnt++;
			end else begin
				$display("test %0d failed with %0d mismatches", test_id, test_errs);
				fail_cnt++;
			end
			test_errs = 0;
		end
	endtask

	// requests come on the falling edge while the outputs are stable
	always @(posedge check_req) begin
		run_check();
	end

endmodule

// File: testbench/tb_stair_game.sv
`timescale 1ns/10ps
`include "stair_params.svh"

module tb_stair_game;

	localparam logic [2:0] K_IDLE   = 3'd0;
	localparam logic [2:0] K_LAYOUT = 3'd1;
	localparam logic [2:0] K_BOUNCE = 3'd2;
	localparam logic [2:0] K_LANDED = 3'd3;
	localparam logic [2:0] K_SCORE  = 3'd4;
	localparam logic [2:0] K_OVER   = 3'd5;
	localparam int N_TESTS = 7;

	typedef struct packed {
		logic       do_rst;
		logic       start;
		logic       left;
		logic       right;
		logic [4:0] steps;
		logic [9:0] score;
		logic       playing;
		logic [2:0] kind;
	} test_row_t;

	logic       clk;
	logic       rst;
	logic       start;
	logic       left;
	logic       right;
	logic [7:0] row;
	logic [7:0] col;
	logic [7:0] seg7_3;
	logic [7:0] seg7_2;
	logic [7:0] seg7_1;
	logic       playing;
	logic       check_req;
	logic       check_last;
	logic [2:0] check_kind;
	int         exp_score;
	logic       exp_playing;
	int         exp_y;
	int         test_id;
	int         pass_cnt;
	int         fail_cnt;
	test_row_t  table_rows [N_TESTS];
	int         bounce_y [4] = '{3, 4, 3, 2}; // no input jump pattern
	int unsigned seed = 32'hbe60bc42;

	stair_game i_stair_game (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.left    (left),
		.right   (right),
		.row     (row),
		.col     (col),
		.seg7_3  (seg7_3),
		.seg7_2  (seg7_2),
		.seg7_1  (seg7_1),
		.playing (playing)
	);

	stair_checker stair_checker (
		.clk         (clk),
		.row         (row),
		.col         (col),
		.seg_h       (seg7_3),
		.seg_t       (seg7_2),
		.seg_o       (seg7_1),
		.playing     (playing),
		.check_req   (check_req),
		.check_last  (check_last),
		.check_kind  (check_kind),
		.exp_score   (exp_score),
		.exp_playing (exp_playing),
		.exp_y       (exp_y),
		.test_id     (test_id),
		.pass_cnt    (pass_cnt),
		.fail_cnt    (fail_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic apply_reset();
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic wait_step();
		@(negedge clk);
		while (!i_stair_game.ctrl.step) @(negedge clk);
	endtask

	task automatic request_check(input logic [2:0] kind, input int y, input logic last);
		check_kind = kind;
		exp_y      = y;
		check_last = last;
		check_req  = 1'b1;
		@(negedge clk);
		check_req = 1'b0;
	endtask

	// rst, start, left, right, steps, score, playing, check
	initial begin
		table_rows[0] = {1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 10'd0, 1'b0, K_IDLE};
		table_rows[1] = {1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 10'd0, 1'b1, K_LAYOUT};
		table_rows[2] = {1'b0, 1'b0, 1'b0, 1'b0, 5'd8, 10'd0, 1'b1, K_BOUNCE};
		table_rows[3] = {1'b1, 1'b1, 1'b1, 1'b0, 5'd3, 10'd1, 1'b1, K_LANDED};
		table_rows[4] = {1'b0, 1'b0, 1'b1, 1'b0, 5'd8, 10'd1, 1'b1, K_SCORE};
		table_rows[5] = {1'b1, 1'b1, 1'b0, 1'b1, 5'd6, 10'd0, 1'b0, K_OVER};
		table_rows[6] = {1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 10'd0, 1'b1, K_LAYOUT};
	end

	// run length follows from the steps in the table
	initial begin
		longint total_steps;
		total_steps = 0;
		#1;
		for (int i = 0; i < N_TESTS; i++) begin
			total_steps += table_rows[i].steps;
		end
		#((total_steps * `GAME_MOVE_TICKS + N_TESTS * 200) * 100);
		$display("timeout: the game did not reach the expected state in time");
		$display("TEST FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// stimulus loop
	initial begin
		rst         = 1'b1;
		start       = 1'b0;
		left        = 1'b0;
		right       = 1'b0;
		check_req   = 1'b0;
		check_last  = 1'b0;
		check_kind  = K_IDLE;
		exp_score   = 0;
		exp_playing = 1'b0;
		exp_y       = 0;
		test_id     = 0;
		void'($urandom(seed));
		apply_reset();
		for (int t = 0; t < N_TESTS; t++) begin
			test_id     = t;
			exp_score   = table_rows[t].score;
			exp_playing = table_rows[t].playing;
			if (table_rows[t].do_rst) begin
				apply_reset();
			end
			left  = table_rows[t].left;
			right = table_rows[t].right;
			if (table_rows[t].start) begin
				start = 1'b1;
				@(negedge clk);
				while (!playing) @(negedge clk); // held until the game starts
				start = 1'b0;
			end
			for (int s = 0; s < table_rows[t].steps; s++) begin
				wait_step();
				if (table_rows[t].kind == K_BOUNCE) begin
					repeat (10) @(negedge clk); // let a full frame pass
					request_check(K_BOUNCE, bounce_y[s % 4], s == table_rows[t].steps - 1);
				end
			end
			if (table_rows[t].kind == K_LANDED) begin
				while (!i_stair_game.stair_added) @(negedge clk);
				repeat (11) @(negedge clk);
			end else if (table_rows[t].kind == K_OVER) begin
				while (playing) @(negedge clk);
				repeat (12) @(negedge clk);
			end else begin
				repeat (12) @(negedge clk);
			end
			if (table_rows[t].kind != K_BOUNCE) begin
				request_check(table_rows[t].kind, 0, 1'b1);
			end
			repeat ($urandom_range(4, 1)) @(negedge clk); // idle gap
		end
		repeat (2) @(negedge clk);
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/stair_pkg.sv
source/game_fsm.sv
source/player_motion.sv
source/stair_field.sv
source/score_display.sv
source/matrix_scan.sv
source/stair_game.sv
testbench/stair_checker.sv
testbench/tb_stair_game.sv
